/* design/arbiter_fsm.sv */
`timescale 1ns/10ps
`include "arbiter_settings.svh"

module arbiter_fsm (
  input  logic                   CLK,
  input  logic                   nRST,
  input  arbiter_pkg::sp_req_t    sp_req,
  input  arbiter_pkg::cache_req_t cache_req,
  input  ram_bus_pkg::ram_rsp_t   ram_rsp,
  output arbiter_pkg::grant_t     grant,
  output logic                   sp_wait,
  output logic                   dwait,
  output logic                   iwait,
  output logic                   sload_hit,
  output logic                   sstore_hit,
  output logic                   sp_capture,
  output logic                   d_capture,
  output logic                   i_capture,
  output logic [1:0]             sload_row
);

  import arbiter_pkg::*;

  grant_t state;
  grant_t next_state;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Fixed priority pick in IDLE and hold until the RAM answers
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (sp_req.sload) begin
          next_state = SP_LOAD;
        end else if (sp_req.sstore) begin
          next_state = SP_STORE;
        end else if (cache_req.dren || cache_req.dwen) begin
          next_state = DCACHE;
        end else if (cache_req.iren) begin
          next_state = ICACHE;
        end
      end
      SP_LOAD, SP_STORE, DCACHE, ICACHE: begin
        if (ram_rsp.ramhit) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  assign grant = state;

  // Wait drops only in the hit cycle of the owning grant
  assign sload_hit  = (state == SP_LOAD) && ram_rsp.ramhit;
  assign sstore_hit = (state == SP_STORE) && ram_rsp.ramhit;
  assign sp_wait    = !(sload_hit || sstore_hit);
  assign dwait      = !((state == DCACHE) && ram_rsp.ramhit);
  assign iwait      = !((state == ICACHE) && ram_rsp.ramhit);

  // Only read data is latched so a dcache write leaves dload alone
  assign sp_capture = sload_hit;
  assign d_capture  = (state == DCACHE) && ram_rsp.ramhit && cache_req.dren;
  assign i_capture  = (state == ICACHE) && ram_rsp.ramhit;

  // Count of completed scratchpad loads that wraps at four
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      sload_row <= 2'd0;
    end else if (sload_hit) begin
      sload_row <= sload_row + 2'd1;
    end
  end

  // RAM must stay quiet while nothing is granted
  a_no_hit_in_idle: assert property (
    @(posedge CLK) disable iff (!nRST)
    (state == IDLE) |-> !ram_rsp.ramhit
  );

  // A new grant is answered in its RAM_LATENCY-th cycle
  a_hit_on_time: assert property (
    @(posedge CLK) disable iff (!nRST)
    (state != IDLE && $past(state) == IDLE) |-> ##(`RAM_LATENCY - 1) ram_rsp.ramhit
  );

endmodule

/* design/arbiter_pkg.sv */
`include "arbiter_settings.svh"

package arbiter_pkg;

  // Scratchpad side, load and store ports
  typedef struct packed {
    logic                  sload;
    logic                  sstore;
    logic [`ADDR_W-1:0]    load_addr;
    logic [`ADDR_W-1:0]    store_addr;
    logic [`SP_DATA_W-1:0] store_data;
  } sp_req_t;

  // Data cache and instruction cache ports
  typedef struct packed {
    logic                 dren;
    logic                 dwen;
    logic                 iren;
    logic [`ADDR_W-1:0]   daddr;
    logic [`ADDR_W-1:0]   iaddr;
    logic [`C_DATA_W-1:0] dstore;
  } cache_req_t;

  typedef struct packed {
    logic [`SP_DATA_W-1:0] load_data;
    logic [1:0]            sload_row;
    logic                  sp_wait;
    logic                  sload_hit;
    logic                  sstore_hit;
  } sp_rsp_t;

  typedef struct packed {
    logic [`C_DATA_W-1:0] dload;
    logic [`C_DATA_W-1:0] iload;
    logic                 dwait;
    logic                 iwait;
  } cache_rsp_t;

  // Grant states, listed in priority order after IDLE
  typedef enum logic [2:0] {
    IDLE     = 3'b000,
    SP_LOAD  = 3'b001,
    SP_STORE = 3'b010,
    DCACHE   = 3'b011,
    ICACHE   = 3'b100
  } grant_t;

endpackage

/* design/arbiter_settings.svh */
`ifndef ARBITER_SETTINGS_SVH
`define ARBITER_SETTINGS_SVH

// Cycles from the start of a RAM access to its hit
`define RAM_LATENCY 2

// RAM depth in words, indexed by the low address bits
`define RAM_WORDS 256

// Word address width
`define ADDR_W 32

// Scratchpad payload, also the RAM word width
`define SP_DATA_W 64

// Cache payload, zero-extended into the RAM word
`define C_DATA_W 32

`endif

/* design/latency_ram.sv */
`timescale 1ns/10ps
`include "arbiter_settings.svh"

module latency_ram (
  input  logic                  CLK,
  input  logic                  nRST,
  input  ram_bus_pkg::ram_req_t ram_req,
  output ram_bus_pkg::ram_rsp_t ram_rsp
);

  localparam int IDX_W = $clog2(`RAM_WORDS);
  localparam int CNT_W = $clog2(`RAM_LATENCY + 1);

  logic [`SP_DATA_W-1:0] mem [`RAM_WORDS];
  logic [IDX_W-1:0]      idx;
  logic [CNT_W-1:0]      cnt;
  logic                  active;
  logic                  hit;

  assign idx    = ram_req.addr[IDX_W-1:0];
  assign active = ram_req.ren || ram_req.wen;

  // Hit in the RAM_LATENCY-th active cycle
  assign hit = active && (cnt == CNT_W'(`RAM_LATENCY - 1));

  // Cycles spent on the current access
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end else if (!active || hit) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Write lands on the hit edge
  always_ff @(posedge CLK) begin
    if (hit && ram_req.wen) begin
      mem[idx] <= ram_req.wdat;
    end
  end

  assign ram_rsp.rdat   = mem[idx];
  assign ram_rsp.ramhit = hit;

  // Requester side must hold its address until the access completes
  a_addr_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (active && !hit) |=> (active && ram_req.addr == $past(ram_req.addr))
  );

endmodule

/* design/memory_arbiter_top.sv */
`timescale 1ns/10ps
`include "arbiter_settings.svh"

module memory_arbiter_top (
  input  logic                    CLK,
  input  logic                    nRST,
  input  arbiter_pkg::sp_req_t    sp_req,
  input  arbiter_pkg::cache_req_t cache_req,
  output arbiter_pkg::sp_rsp_t    sp_rsp,
  output arbiter_pkg::cache_rsp_t cache_rsp
);

  import arbiter_pkg::*;
  import ram_bus_pkg::*;

  grant_t   grant;
  ram_req_t ram_req;
  ram_rsp_t ram_rsp;

  logic sp_capture;
  logic d_capture;
  logic i_capture;

  logic [`SP_DATA_W-1:0] sp_load_data;
  logic [`C_DATA_W-1:0]  d_load_data;
  logic [`C_DATA_W-1:0]  i_load_data;

  arbiter_fsm i_arbiter_fsm (
    .CLK        (CLK),
    .nRST       (nRST),
    .sp_req     (sp_req),
    .cache_req  (cache_req),
    .ram_rsp    (ram_rsp),
    .grant      (grant),
    .sp_wait    (sp_rsp.sp_wait),
    .dwait      (cache_rsp.dwait),
    .iwait      (cache_rsp.iwait),
    .sload_hit  (sp_rsp.sload_hit),
    .sstore_hit (sp_rsp.sstore_hit),
    .sp_capture (sp_capture),
    .d_capture  (d_capture),
    .i_capture  (i_capture),
    .sload_row  (sp_rsp.sload_row)
  );

  request_mux i_request_mux (
    .grant     (grant),
    .sp_req    (sp_req),
    .cache_req (cache_req),
    .ram_req   (ram_req)
  );

  latency_ram i_latency_ram (
    .CLK     (CLK),
    .nRST    (nRST),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

  // Full RAM word for the scratchpad
  response_latch #(.payload_t(logic [`SP_DATA_W-1:0])) i_sp_latch (
    .CLK     (CLK),
    .nRST    (nRST),
    .capture (sp_capture),
    .ram_rsp (ram_rsp),
    .data    (sp_load_data)
  );

  // Low half for each cache port
  response_latch #(.payload_t(logic [`C_DATA_W-1:0])) i_d_latch (
    .CLK     (CLK),
    .nRST    (nRST),
    .capture (d_capture),
    .ram_rsp (ram_rsp),
    .data    (d_load_data)
  );

  response_latch #(.payload_t(logic [`C_DATA_W-1:0])) i_i_latch (
    .CLK     (CLK),
    .nRST    (nRST),
    .capture (i_capture),
    .ram_rsp (ram_rsp),
    .data    (i_load_data)
  );

  assign sp_rsp.load_data = sp_load_data;
  assign cache_rsp.dload  = d_load_data;
  assign cache_rsp.iload  = i_load_data;

endmodule

/* design/ram_bus_pkg.sv */
`include "arbiter_settings.svh"

package ram_bus_pkg;

  // Request from the arbiter to the RAM
  // At most one of wen and ren is high
  typedef struct packed {
    logic                  wen;
    logic                  ren;
    logic [`ADDR_W-1:0]    addr;
    logic [`SP_DATA_W-1:0] wdat;
  } ram_req_t;

  // Response from the RAM
  // ramhit pulses for one cycle when the access completes
  typedef struct packed {
    logic [`SP_DATA_W-1:0] rdat;
    logic                  ramhit;
  } ram_rsp_t;

endpackage

/* design/request_mux.sv */
`timescale 1ns/10ps
`include "arbiter_settings.svh"

module request_mux (
  input  arbiter_pkg::grant_t     grant,
  input  arbiter_pkg::sp_req_t    sp_req,
  input  arbiter_pkg::cache_req_t cache_req,
  output ram_bus_pkg::ram_req_t   ram_req
);

  import arbiter_pkg::*;

  always_comb begin
    ram_req = '0;
    case (grant)
      SP_LOAD: begin
        ram_req.ren  = 1'b1;
        ram_req.addr = sp_req.load_addr;
      end
      SP_STORE: begin
        ram_req.wen  = 1'b1;
        ram_req.addr = sp_req.store_addr;
        ram_req.wdat = sp_req.store_data;
      end
      DCACHE: begin
        ram_req.ren  = cache_req.dren;
        ram_req.wen  = cache_req.dwen;
        ram_req.addr = cache_req.daddr;
        // Cache word sits in the low half of the RAM word
        ram_req.wdat = {{(`SP_DATA_W - `C_DATA_W){1'b0}}, cache_req.dstore};
      end
      ICACHE: begin
        ram_req.ren  = 1'b1;
        ram_req.addr = cache_req.iaddr;
      end
      default: ram_req = '0;
    endcase
  end

  // Catches a dcache raising read and write together
  always_comb begin
    a_one_enable: assert (!(ram_req.wen && ram_req.ren))
      else $error("request_mux: wen and ren both high in grant %s", grant.name());
  end

endmodule

/* design/response_latch.sv */
`timescale 1ns/10ps

module response_latch #(
  parameter type payload_t = logic [63:0]
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  capture,
  input  ram_bus_pkg::ram_rsp_t ram_rsp,
  output payload_t              data
);

  // Narrow payloads keep the low bits of the RAM word
  payload_t rdat_slice;

  assign rdat_slice = payload_t'(ram_rsp.rdat);

  // Holds the last read for its requester until the next capture
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      data <= '0;
    end else if (capture) begin
      data <= rdat_slice;
    end
  end

  // Capture strobes come from the FSM in the hit cycle only
  a_capture_on_hit: assert property (
    @(posedge CLK) disable iff (!nRST)
    capture |-> ram_rsp.ramhit
  );

endmodule

/* flist.f */
+incdir+design
+incdir+testbench
design/ram_bus_pkg.sv
design/arbiter_pkg.sv
design/arbiter_fsm.sv
design/request_mux.sv
design/response_latch.sv
design/latency_ram.sv
design/memory_arbiter_top.sv
testbench/tb_memory_arbiter.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_memory_arbiter -o sim_memory_arbiter
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_memory_arbiter > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test completed successfully" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* testbench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// One mismatch line, then the run stops
task automatic report_mismatch(input string name, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
  $display("CHECK FAILED %s %s expected %h actual %h", name, field, exp, act);
  stop_with_failure();
endtask

// Scratchpad response, field by field
task automatic check_sp_rsp(input string name, input arbiter_pkg::sp_rsp_t exp,
                            input arbiter_pkg::sp_rsp_t act);
  if (act.load_data !== exp.load_data) begin
    report_mismatch(name, "load_data", exp.load_data, act.load_data);
  end
  if (act.sload_row !== exp.sload_row) begin
    report_mismatch(name, "sload_row", 64'(exp.sload_row), 64'(act.sload_row));
  end
  // Flags as {sp_wait, sload_hit, sstore_hit}
  if ({act.sp_wait, act.sload_hit, act.sstore_hit} !==
      {exp.sp_wait, exp.sload_hit, exp.sstore_hit}) begin
    report_mismatch(name, "wait_hit_flags",
                    64'({exp.sp_wait, exp.sload_hit, exp.sstore_hit}),
                    64'({act.sp_wait, act.sload_hit, act.sstore_hit}));
  end
endtask

// Cache response, field by field
task automatic check_cache_rsp(input string name, input arbiter_pkg::cache_rsp_t exp,
                               input arbiter_pkg::cache_rsp_t act);
  if (act.dload !== exp.dload) begin
    report_mismatch(name, "dload", 64'(exp.dload), 64'(act.dload));
  end
  if (act.iload !== exp.iload) begin
    report_mismatch(name, "iload", 64'(exp.iload), 64'(act.iload));
  end
  // Flags as {dwait, iwait}
  if ({act.dwait, act.iwait} !== {exp.dwait, exp.iwait}) begin
    report_mismatch(name, "wait_flags", 64'({exp.dwait, exp.iwait}),
                    64'({act.dwait, act.iwait}));
  end
endtask

`endif

/* testbench/tb_memory_arbiter.sv */
`timescale 1ns/10ps
`include "arbiter_settings.svh"

module tb_memory_arbiter;

  import arbiter_pkg::*;

  typedef enum logic [2:0] {
    OP_SP_LOAD,
    OP_SP_STORE,
    OP_D_READ,
    OP_D_WRITE,
    OP_I_READ,
    OP_GROUP
  } op_t;

  // One stimulus row, row is the expected sload_row after it
  typedef struct {
    op_t         op;
    logic [31:0] addr;
    logic [1:0]  row;
    string       name;
  } entry_t;

  localparam int N_TESTS    = 11;
  localparam int IDX_W      = $clog2(`RAM_WORDS);
  localparam int TIMEOUT_NS = N_TESTS * (`RAM_LATENCY + 4) * 4 * 2 + 3 * 4;

  logic       CLK;
  logic       nRST;
  sp_req_t    sp_req;
  cache_req_t cache_req;
  sp_rsp_t    sp_rsp;
  cache_rsp_t cache_rsp;

  entry_t      tests [N_TESTS];
  logic [63:0] ref_mem [`RAM_WORDS];
  sp_rsp_t     exp_sp;
  cache_rsp_t  exp_c;
  integer      seed = 32'hc861;

  memory_arbiter_top i_memory_arbiter_top (
    .CLK       (CLK),
    .nRST      (nRST),
    .sp_req    (sp_req),
    .cache_req (cache_req),
    .sp_rsp    (sp_rsp),
    .cache_rsp (cache_rsp)
  );

  always #2 CLK = ~CLK;

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "tb_checks.svh"

  function automatic void load_tests();
    tests[0]  = '{OP_SP_STORE, 32'h10, 2'd0, "sp_store_10"};
    // Five loads in a row, count wraps past 3
    tests[1]  = '{OP_SP_LOAD,  32'h10, 2'd1, "sp_load_a"};
    tests[2]  = '{OP_SP_LOAD,  32'h10, 2'd2, "sp_load_b"};
    tests[3]  = '{OP_SP_LOAD,  32'h10, 2'd3, "sp_load_c"};
    tests[4]  = '{OP_SP_LOAD,  32'h10, 2'd0, "sp_load_d"};
    tests[5]  = '{OP_SP_LOAD,  32'h10, 2'd1, "sp_load_e"};
    tests[6]  = '{OP_D_WRITE,  32'h20, 2'd1, "d_write_20"};
    tests[7]  = '{OP_D_READ,   32'h20, 2'd1, "d_read_20"};
    tests[8]  = '{OP_I_READ,   32'h20, 2'd1, "i_read_20"};
    tests[9]  = '{OP_SP_STORE, 32'h40, 2'd1, "sp_store_40"};
    tests[10] = '{OP_GROUP,    32'h40, 2'd2, "group_40"};
  endfunction

  task automatic raise_request(input op_t op, input logic [31:0] addr,
                               input logic [63:0] data);
    case (op)
      OP_SP_LOAD: begin
        sp_req.sload     = 1'b1;
        sp_req.load_addr = addr;
      end
      OP_SP_STORE: begin
        sp_req.sstore     = 1'b1;
        sp_req.store_addr = addr;
        sp_req.store_data = data;
      end
      OP_D_READ: begin
        cache_req.dren  = 1'b1;
        cache_req.daddr = addr;
      end
      OP_D_WRITE: begin
        cache_req.dwen   = 1'b1;
        cache_req.daddr  = addr;
        cache_req.dstore = data[31:0];
      end
      OP_I_READ: begin
        cache_req.iren  = 1'b1;
        cache_req.iaddr = addr;
      end
      default: begin
      end
    endcase
  endtask

  // Address and data stay put, only the level goes
  task automatic drop_request(input op_t op);
    case (op)
      OP_SP_LOAD:  sp_req.sload   = 1'b0;
      OP_SP_STORE: sp_req.sstore  = 1'b0;
      OP_D_READ:   cache_req.dren = 1'b0;
      OP_D_WRITE:  cache_req.dwen = 1'b0;
      OP_I_READ:   cache_req.iren = 1'b0;
      default: begin
      end
    endcase
  endtask

  // Waits for the hit of one requester, checks it and the cycle after
  task automatic complete_op(input string name, input op_t op, input logic [31:0] addr,
                             input logic [63:0] data, input logic [1:0] row_after);
    sp_rsp_t          hit_sp;
    cache_rsp_t       hit_c;
    logic [IDX_W-1:0] idx;
    idx    = addr[IDX_W-1:0];
    hit_sp = exp_sp;
    hit_c  = exp_c;
    case (op)
      OP_SP_LOAD: begin
        hit_sp.sp_wait   = 1'b0;
        hit_sp.sload_hit = 1'b1;
      end
      OP_SP_STORE: begin
        hit_sp.sp_wait    = 1'b0;
        hit_sp.sstore_hit = 1'b1;
      end
      OP_D_READ, OP_D_WRITE: hit_c.dwait = 1'b0;
      default: hit_c.iwait = 1'b0;
    endcase
    do begin
      @(negedge CLK);
    end while (sp_rsp.sp_wait && cache_rsp.dwait && cache_rsp.iwait);
    // Every other port must still be waiting here
    check_sp_rsp({name, " hit"}, hit_sp, sp_rsp);
    check_cache_rsp({name, " hit"}, hit_c, cache_rsp);
    @(posedge CLK);
    #0.5;
    drop_request(op);
    case (op)
      OP_SP_LOAD:  exp_sp.load_data = ref_mem[idx];
      OP_SP_STORE: ref_mem[idx] = data;
      OP_D_READ:   exp_c.dload = ref_mem[idx][31:0];
      OP_D_WRITE:  ref_mem[idx] = {32'd0, data[31:0]};
      default:     exp_c.iload = ref_mem[idx][31:0];
    endcase
    exp_sp.sload_row = row_after;
    @(negedge CLK);
    check_sp_rsp(name, exp_sp, sp_rsp);
    check_cache_rsp(name, exp_c, cache_rsp);
  endtask

  task automatic run_entry(input entry_t e);
    logic [63:0] data;
    data = {$random(seed), $random(seed)};
    if (e.op == OP_GROUP) begin
      // All four at once, served strictly by priority
      raise_request(OP_SP_LOAD, e.addr, data);
      raise_request(OP_SP_STORE, e.addr, data);
      raise_request(OP_D_READ, e.addr, data);
      raise_request(OP_I_READ, e.addr, data);
      complete_op({e.name, " sp_load"}, OP_SP_LOAD, e.addr, data, e.row);
      complete_op({e.name, " sp_store"}, OP_SP_STORE, e.addr, data, e.row);
      complete_op({e.name, " d_read"}, OP_D_READ, e.addr, data, e.row);
      complete_op({e.name, " i_read"}, OP_I_READ, e.addr, data, e.row);
    end else begin
      raise_request(e.op, e.addr, data);
      complete_op(e.name, e.op, e.addr, data, e.row);
    end
    @(posedge CLK);
    #0.5;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Simulation timed out before all tests finished");
    stop_with_failure();
  end

  initial begin
    CLK       = 1'b0;
    nRST      = 1'b0;
    sp_req    = '0;
    cache_req = '0;
    load_tests();
    exp_sp         = '0;
    exp_sp.sp_wait = 1'b1;
    exp_c          = '0;
    exp_c.dwait    = 1'b1;
    exp_c.iwait    = 1'b1;
    repeat (3) @(posedge CLK);
    #0.5;
    nRST = 1'b1;
    @(negedge CLK);
    check_sp_rsp("after_reset", exp_sp, sp_rsp);
    check_cache_rsp("after_reset", exp_c, cache_rsp);
    @(posedge CLK);
    #0.5;
    for (int i = 0; i < N_TESTS; i++) begin
      run_entry(tests[i]);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule
